// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the memory path testbench with Verilator, run it and judge the result from the log
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -f "$log"

verilator --binary --timing --assert -f verilog.f --top-module tb_mem_subsys \
  > "$log" 2>&1 && ./obj_dir/Vtb_mem_subsys >> "$log" 2>&1

cat "$log"
grep -qx "TEST PASSED" "$log" && echo "Simulation passed" || {
  echo "Simulation failed"
  exit 1
}

// ==== test/mem_subsys_properties.sv ====
// Concurrent checks on the AXI-lite master bridge outputs; bound into every bridge instance
`timescale 1ns/1ps

module mem_subsys_properties (
  input logic                i_aclk,
  input logic                i_arst_n,
  input logic                i_aw_valid,
  input axil_pkg::axil_aw_t  i_aw,
  input logic                i_aw_ready,
  input logic                i_w_valid,
  input axil_pkg::axil_w_t   i_w,
  input logic                i_w_ready,
  input logic                i_ar_valid,
  input axil_pkg::axil_ar_t  i_ar,
  input logic                i_ar_ready,
  input logic                i_req_done
);

  import axil_pkg::*;

  // ----------------------------------------
  // Valid held with steady payload
  // ----------------------------------------
  aw_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    i_aw_valid && !i_aw_ready |=> i_aw_valid && $stable(i_aw))
    else $error("aw valid or payload changed before handshake");

  w_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    i_w_valid && !i_w_ready |=> i_w_valid && $stable(i_w))
    else $error("w valid or payload changed before handshake");

  ar_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    i_ar_valid && !i_ar_ready |=> i_ar_valid && $stable(i_ar))
    else $error("ar valid or payload changed before handshake");

  // Completion is a single-cycle pulse
  done_pulse: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    i_req_done |=> !i_req_done)
    else $error("done held high for more than one cycle");

  aw_prot: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    i_aw_valid |-> i_aw.prot == AXI_PROT_DATA)
    else $error("aw prot differs from the data access value");

  ar_prot: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    i_ar_valid |-> i_ar.prot == AXI_PROT_DATA)
    else $error("ar prot differs from the data access value");

endmodule

bind axil_master_bridge mem_subsys_properties u_props (
  .i_aclk     (i_aclk),
  .i_arst_n   (i_arst_n),
  .i_aw_valid (o_aw_valid),
  .i_aw       (o_aw),
  .i_aw_ready (i_aw_ready),
  .i_w_valid  (o_w_valid),
  .i_w        (o_w),
  .i_w_ready  (i_w_ready),
  .i_ar_valid (o_ar_valid),
  .i_ar       (o_ar),
  .i_ar_ready (i_ar_ready),
  .i_req_done (o_req_done)
);

// ==== test/tb_mem_subsys.sv ====
// Testbench for the memory path; drives fetch and data ports and checks against a shadow memory
`timescale 1ns/1ps

module tb_mem_subsys;

  import axil_pkg::*;

  localparam int CLK_PERIOD      = 20;
  localparam int RESET_CYCLES    = 10;
  localparam int IDLE_CYCLES     = 20;
  localparam int NUM_WORDS       = 8;                       // Words seeded in the first phase
  localparam int NUM_REQS        = 2*NUM_WORDS + 8 + 4 + 6 + 12;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + IDLE_CYCLES + NUM_REQS*20 + 100;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              err;
  } resp_t;

  logic              aclk;
  logic              arst_n;
  logic              if_valid;
  logic [ADDR_W-1:0] if_addr;
  logic              if_ready;
  logic [DATA_W-1:0] if_rdata;
  logic              if_err;
  logic              mem_valid;
  mem_req_t          mem_req;
  logic              mem_ready;
  logic [DATA_W-1:0] mem_rdata;
  logic              mem_err;

  logic [DATA_W-1:0] shadow [MEM_DEPTH];
  logic [IDX_W-1:0]  written [NUM_WORDS];              // Word indices known to hold data
  resp_t             mem_exp_q[$];
  resp_t             if_exp_q[$];
  string             test_name;
  int                seed;
  int                done_count;
  int                mem_last;                         // Completion order of the last access
  int                if_last;

  mem_subsys_top u_dut (
    .i_aclk      (aclk),
    .i_arst_n    (arst_n),
    .i_if_valid  (if_valid),
    .i_if_addr   (if_addr),
    .o_if_ready  (if_ready),
    .o_if_rdata  (if_rdata),
    .o_if_err    (if_err),
    .i_mem_valid (mem_valid),
    .i_mem_req   (mem_req),
    .o_mem_ready (mem_ready),
    .o_mem_rdata (mem_rdata),
    .o_mem_err   (mem_err)
  );

  initial begin
    aclk = 1'b0;
    forever #(CLK_PERIOD/2) aclk = ~aclk;
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  // Expected response of one access; writes update the shadow under their strobes
  function automatic resp_t model_access(input mem_req_t req);
    resp_t            res;
    logic             in_rng;
    logic [IDX_W-1:0] idx;
    in_rng   = (req.addr[ADDR_W-1:WORD_LSB+IDX_W] == '0);
    idx      = req.addr[WORD_LSB +: IDX_W];
    res.err  = ~in_rng;
    res.data = '0;
    if (req.wen) begin
      if (in_rng) begin
        for (int lane = 0; lane < STRB_W; lane++) begin
          if (req.wstrb[lane]) shadow[idx][8*lane +: 8] = req.wdata[8*lane +: 8];
        end
      end
    end else if (in_rng) begin
      res.data = shadow[idx];
    end
    return res;
  endfunction

  function automatic logic [ADDR_W-1:0] word_addr(input logic [IDX_W-1:0] idx);
    return {{(ADDR_W-IDX_W-WORD_LSB){1'b0}}, idx, {WORD_LSB{1'b0}}};
  endfunction

  function automatic logic [DATA_W-1:0] rand_data();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  function automatic mem_req_t write_req(input logic [ADDR_W-1:0] addr,
                                         input logic [DATA_W-1:0] data,
                                         input logic [STRB_W-1:0] strb);
    return '{ren: 1'b0, wen: 1'b1, addr: addr, wdata: data, wstrb: strb};
  endfunction

  function automatic mem_req_t read_req(input logic [ADDR_W-1:0] addr);
    return '{ren: 1'b1, wen: 1'b0, addr: addr, wdata: '0, wstrb: '0};
  endfunction

  // ----------------------------------------
  // Checking
  // ----------------------------------------
  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("ERR %s %s: expected %h, actual %h", test_name, what, expected, actual);
      abort_run();
    end
  endtask

  // Compare each ready pulse with the oldest expected response of its port
  always @(negedge aclk) begin : compare
    resp_t want;
    if (arst_n) begin
      if (mem_ready) begin
        if (!mem_valid || mem_exp_q.size() == 0) begin
          $display("Data port ready pulsed with no request pending");
          abort_run();
        end else begin
          want = mem_exp_q.pop_front();
          check_value("data rdata", want.data, mem_rdata);
          check_value("data err", {63'd0, want.err}, {63'd0, mem_err});
          done_count++;
          mem_last = done_count;
        end
      end
      if (if_ready) begin
        if (!if_valid || if_exp_q.size() == 0) begin
          $display("Fetch port ready pulsed with no request pending");
          abort_run();
        end else begin
          want = if_exp_q.pop_front();
          check_value("fetch rdata", want.data, if_rdata);
          check_value("fetch err", {63'd0, want.err}, {63'd0, if_err});
          done_count++;
          if_last = done_count;
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge aclk);
    $display("Watchdog expired after %0d cycles with requests still open", WATCHDOG_CYCLES);
    abort_run();
  end

  // ----------------------------------------
  // Requester drivers
  // ----------------------------------------
  task automatic run_mem(input mem_req_t req);
    mem_exp_q.push_back(model_access(req));
    @(posedge aclk);
    mem_valid <= 1'b1;
    mem_req   <= req;
    @(negedge aclk);
    while (!mem_ready) @(negedge aclk);                // Hold until the ready pulse
    @(posedge aclk);
    mem_valid <= 1'b0;
  endtask

  task automatic run_fetch(input logic [ADDR_W-1:0] addr);
    if_exp_q.push_back(model_access(read_req(addr)));
    @(posedge aclk);
    if_valid <= 1'b1;
    if_addr  <= addr;
    @(negedge aclk);
    while (!if_ready) @(negedge aclk);
    @(posedge aclk);
    if_valid <= 1'b0;
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    logic [31:0]       rnd;
    logic [ADDR_W-1:0] addr;
    logic [STRB_W-1:0] strb;
    seed       = 32'h85ed;
    done_count = 0;
    mem_last   = 0;
    if_last    = 0;
    arst_n     = 1'b0;
    if_valid   = 1'b0;
    if_addr    = '0;
    mem_valid  = 1'b0;
    mem_req    = '0;
    repeat (RESET_CYCLES) @(posedge aclk);
    arst_n <= 1'b1;

    test_name = "idle_after_reset";
    repeat (IDLE_CYCLES) begin
      @(negedge aclk);
      check_value("ready", 64'd0, {62'd0, if_ready, mem_ready});
      check_value("rdata", 64'd0, if_rdata);
      check_value("data rdata", 64'd0, mem_rdata);
    end

    test_name = "full_write_read";
    for (int i = 0; i < NUM_WORDS; i++) begin
      rnd        = $random(seed);
      written[i] = rnd[IDX_W-1:0];
      addr       = word_addr(written[i]);
      run_mem(write_req(addr, rand_data(), '1));
      run_mem(read_req(addr));
    end

    test_name = "partial_strobe";
    for (int i = 0; i < 4; i++) begin
      rnd  = $random(seed);
      strb = rnd[STRB_W-1:0];
      if (strb == '0 || strb == '1) strb = 8'h5a;      // Keep it a true partial write
      addr = word_addr(written[i]);
      run_mem(write_req(addr, rand_data(), strb));
      run_mem(read_req(addr));
    end

    test_name = "fetch_shared_memory";
    for (int i = 0; i < 4; i++) begin
      run_fetch(word_addr(written[NUM_WORDS-1-i]));
    end

    test_name = "contention";
    for (int i = 0; i < 3; i++) begin
      fork
        run_mem(read_req(word_addr(written[i])));
        run_fetch(word_addr(written[i+4]));
      join
      check_value("data first", 64'd1, {63'd0, mem_last < if_last});
    end

    test_name = "out_of_range";
    for (int i = 0; i < 3; i++) begin
      rnd  = $random(seed);
      addr = word_addr(written[i]) | {rnd[31:11] | 21'd1, 11'd0};
      run_mem(read_req(addr));
      run_mem(write_req(addr, rand_data(), '1));
      run_fetch(addr);
      run_mem(read_req(word_addr(written[i])));       // Same word, still untouched
    end

    // Quiet tail so a stray ready pulse still gets caught
    repeat (5) @(posedge aclk);
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== verilog.f ====
verilog/axil_pkg.sv
verilog/mem_req_arbiter.sv
verilog/axil_master_bridge.sv
verilog/axil_sram_slave.sv
verilog/mem_subsys_top.sv
test/mem_subsys_properties.sv
test/tb_mem_subsys.sv

// ==== verilog/axil_master_bridge.sv ====
// AXI-lite master bridge; runs one granted request as a read or write channel sequence
`timescale 1ns/1ps

module axil_master_bridge (
  input  logic                         i_aclk,
  input  logic                         i_arst_n,
  // Granted request
  input  logic                         i_req_valid,
  input  axil_pkg::mem_req_t           i_req,
  output logic                         o_req_done,
  output logic [axil_pkg::DATA_W-1:0]  o_req_rdata,
  output logic                         o_req_err,
  // Write address
  output logic                         o_aw_valid,
  output axil_pkg::axil_aw_t           o_aw,
  input  logic                         i_aw_ready,
  // Write data
  output logic                         o_w_valid,
  output axil_pkg::axil_w_t            o_w,
  input  logic                         i_w_ready,
  // Write response
  input  logic                         i_b_valid,
  input  axil_pkg::axil_b_t            i_b,
  output logic                         o_b_ready,
  // Read address
  output logic                         o_ar_valid,
  output axil_pkg::axil_ar_t           o_ar,
  input  logic                         i_ar_ready,
  // Read data
  input  logic                         i_r_valid,
  input  axil_pkg::axil_r_t            i_r,
  output logic                         o_r_ready
);

  import axil_pkg::*;

  typedef enum logic [1:0] {
    RD_IDLE = 2'd0,
    RD_ADDR = 2'd1,
    RD_READ = 2'd2
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_IDLE  = 2'd0,
    WR_ADDR  = 2'd1,
    WR_WRITE = 2'd2,
    WR_RESP  = 2'd3
  } wr_state_e;

  rd_state_e         rd_state_q;
  rd_state_e         rd_state_d;
  wr_state_e         wr_state_q;
  wr_state_e         wr_state_d;
  logic              start;
  logic              aw_fire;
  logic              w_fire;
  logic              b_fire;
  logic              ar_fire;
  logic              r_fire;
  logic              done_q;
  logic [DATA_W-1:0] rdata_q;
  logic              err_q;

  assign aw_fire = o_aw_valid & i_aw_ready;
  assign w_fire  = o_w_valid  & i_w_ready;
  assign b_fire  = i_b_valid  & o_b_ready;
  assign ar_fire = o_ar_valid & i_ar_ready;
  assign r_fire  = i_r_valid  & o_r_ready;

  // Only one transaction in flight at a time
  assign start = i_req_valid & (rd_state_q == RD_IDLE) & (wr_state_q == WR_IDLE);

  // ----------------------------------------
  // Read FSM
  // ----------------------------------------
  always_comb begin
    rd_state_d = rd_state_q;
    case (rd_state_q)
      RD_IDLE: if (start && i_req.ren && !i_req.wen) rd_state_d = RD_ADDR;
      RD_ADDR: if (ar_fire) rd_state_d = RD_READ;
      RD_READ: if (r_fire)  rd_state_d = RD_IDLE;
      default: rd_state_d = RD_IDLE;
    endcase
  end

  // ----------------------------------------
  // Write FSM
  // ----------------------------------------
  always_comb begin
    wr_state_d = wr_state_q;
    case (wr_state_q)
      WR_IDLE:  if (start && i_req.wen) wr_state_d = WR_ADDR;   // Write wins
      WR_ADDR:  if (aw_fire) wr_state_d = WR_WRITE;
      WR_WRITE: if (w_fire)  wr_state_d = WR_RESP;
      WR_RESP:  if (b_fire)  wr_state_d = WR_IDLE;
      default:  wr_state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_state_q <= RD_IDLE;
      wr_state_q <= WR_IDLE;
    end else begin
      rd_state_q <= rd_state_d;
      wr_state_q <= wr_state_d;
    end
  end

  // ----------------------------------------
  // Channel drive
  // ----------------------------------------
  // Payloads follow the request, which the requester holds stable
  assign o_aw_valid = (wr_state_q == WR_ADDR);
  assign o_aw       = '{addr: i_req.addr, prot: AXI_PROT_DATA};

  assign o_w_valid  = (wr_state_q == WR_WRITE);
  assign o_w        = '{data: i_req.wdata, strb: i_req.wstrb};

  assign o_b_ready  = (wr_state_q == WR_RESP);

  assign o_ar_valid = (rd_state_q == RD_ADDR);
  assign o_ar       = '{addr: i_req.addr, prot: AXI_PROT_DATA};

  assign o_r_ready  = (rd_state_q == RD_READ);

  // ----------------------------------------
  // Completion
  // ----------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      done_q  <= 1'b0;
      rdata_q <= '0;
      err_q   <= 1'b0;
    end else begin
      done_q <= r_fire | b_fire;                       // One-cycle pulse
      if (r_fire) begin
        rdata_q <= i_r.data;
        err_q   <= (i_r.resp != RESP_OKAY);
      end else if (b_fire) begin
        rdata_q <= '0;                                 // Writes return no data
        err_q   <= (i_b.resp != RESP_OKAY);
      end
    end
  end

  assign o_req_done  = done_q;
  assign o_req_rdata = rdata_q;
  assign o_req_err   = err_q;

endmodule

// ==== verilog/axil_pkg.sv ====
// Shared bus sizes, response codes and channel structs; imported by every memory-path module
package axil_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------
  localparam int ADDR_W    = 32;          // Byte address
  localparam int DATA_W    = 64;
  localparam int STRB_W    = DATA_W / 8;  // One strobe per byte lane
  localparam int MEM_DEPTH = 256;         // Words in the SRAM

  // Word index sits above the byte offset
  localparam int WORD_LSB  = 3;
  localparam int IDX_W     = $clog2(MEM_DEPTH);

  // ----------------------------------------
  // AXI-lite constants
  // ----------------------------------------
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Unprivileged, secure, data access
  localparam logic [2:0] AXI_PROT_DATA = 3'b000;

  // ----------------------------------------
  // Requester side
  // ----------------------------------------
  typedef struct packed {
    logic              ren;
    logic              wen;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } mem_req_t;

  // ----------------------------------------
  // AXI-lite channel payloads
  // ----------------------------------------
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [2:0]        prot;
  } axil_aw_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [2:0]        prot;
  } axil_ar_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
  } axil_r_t;

endpackage

// ==== verilog/axil_sram_slave.sv ====
// AXI-lite SRAM slave standing in for system memory; byte strobes and address range check
`timescale 1ns/1ps

module axil_sram_slave (
  input  logic                 i_aclk,
  input  logic                 i_arst_n,
  // Write address
  input  logic                 i_aw_valid,
  input  axil_pkg::axil_aw_t   i_aw,
  output logic                 o_aw_ready,
  // Write data
  input  logic                 i_w_valid,
  input  axil_pkg::axil_w_t    i_w,
  output logic                 o_w_ready,
  // Write response
  output logic                 o_b_valid,
  output axil_pkg::axil_b_t    o_b,
  input  logic                 i_b_ready,
  // Read address
  input  logic                 i_ar_valid,
  input  axil_pkg::axil_ar_t   i_ar,
  output logic                 o_ar_ready,
  // Read data
  output logic                 o_r_valid,
  output axil_pkg::axil_r_t    o_r,
  input  logic                 i_r_ready
);

  import axil_pkg::*;

  logic [DATA_W-1:0] mem [MEM_DEPTH];

  logic              aw_held_q;     // Write address captured, waiting for data
  logic [ADDR_W-1:0] aw_addr_q;
  logic              bvalid_q;
  axil_b_t           b_q;
  logic              rvalid_q;
  axil_r_t           r_q;
  logic              aw_fire;
  logic              w_fire;
  logic              ar_fire;
  logic              aw_ok;
  logic              ar_ok;
  logic [IDX_W-1:0]  aw_idx;
  logic [IDX_W-1:0]  ar_idx;

  // Any bit above the word index means outside the SRAM
  function automatic logic in_range(input logic [ADDR_W-1:0] addr);
    return (addr[ADDR_W-1:WORD_LSB+IDX_W] == '0);
  endfunction

  assign aw_ok  = in_range(aw_addr_q);
  assign ar_ok  = in_range(i_ar.addr);
  assign aw_idx = aw_addr_q[WORD_LSB +: IDX_W];
  assign ar_idx = i_ar.addr[WORD_LSB +: IDX_W];

  // ----------------------------------------
  // Handshakes
  // ----------------------------------------
  assign o_aw_ready = ~aw_held_q & ~bvalid_q;          // Idle write side
  assign o_w_ready  = aw_held_q;
  assign o_ar_ready = ~rvalid_q;                       // Idle read side

  assign aw_fire = i_aw_valid & o_aw_ready;
  assign w_fire  = i_w_valid  & o_w_ready;
  assign ar_fire = i_ar_valid & o_ar_ready;

  // ----------------------------------------
  // Write side
  // ----------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      aw_held_q <= 1'b0;
      bvalid_q  <= 1'b0;
    end else begin
      if (aw_fire) begin
        aw_held_q <= 1'b1;
      end else if (w_fire) begin
        aw_held_q <= 1'b0;
      end

      if (w_fire) begin
        bvalid_q <= 1'b1;                              // Response the cycle after
      end else if (bvalid_q && i_b_ready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      aw_addr_q <= i_aw.addr;
    end
    if (w_fire) begin
      b_q.resp <= aw_ok ? RESP_OKAY : RESP_SLVERR;
      // Out-of-range writes leave memory alone
      if (aw_ok) begin
        for (int lane = 0; lane < STRB_W; lane++) begin
          if (i_w.strb[lane]) begin
            mem[aw_idx][8*lane +: 8] <= i_w.data[8*lane +: 8];
          end
        end
      end
    end
  end

  // ----------------------------------------
  // Read side
  // ----------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rvalid_q <= 1'b0;
    end else if (ar_fire) begin
      rvalid_q <= 1'b1;
    end else if (rvalid_q && i_r_ready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      r_q.data <= ar_ok ? mem[ar_idx] : '0;            // Zero on range error
      r_q.resp <= ar_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign o_b_valid = bvalid_q;
  assign o_b       = b_q;
  assign o_r_valid = rvalid_q;
  assign o_r       = r_q;

endmodule

// ==== verilog/mem_req_arbiter.sv ====
// Request arbiter between fetch and data ports; grant held until the bridge reports done
`timescale 1ns/1ps

module mem_req_arbiter (
  input  logic                         i_aclk,
  input  logic                         i_arst_n,
  // Fetch port
  input  logic                         i_if_valid,
  input  logic [axil_pkg::ADDR_W-1:0]  i_if_addr,
  output logic                         o_if_ready,
  output logic [axil_pkg::DATA_W-1:0]  o_if_rdata,
  output logic                         o_if_err,
  // Data port
  input  logic                         i_mem_valid,
  input  axil_pkg::mem_req_t           i_mem_req,
  output logic                         o_mem_ready,
  output logic [axil_pkg::DATA_W-1:0]  o_mem_rdata,
  output logic                         o_mem_err,
  // Toward the bridge
  output logic                         o_req_valid,
  output axil_pkg::mem_req_t           o_req,
  input  logic                         i_req_done,
  input  logic [axil_pkg::DATA_W-1:0]  i_req_rdata,
  input  logic                         i_req_err
);

  import axil_pkg::*;

  logic     busy_q;      // Grant locked
  logic     own_mem_q;   // Data port owns the grant
  logic     pick_mem;
  logic     own_mem;
  mem_req_t if_req;

  // Fetch only ever reads a whole word
  assign if_req = '{ren: 1'b1, wen: 1'b0, addr: i_if_addr, wdata: '0, wstrb: '0};

  // ----------------------------------------
  // Grant selection
  // ----------------------------------------
  assign pick_mem = i_mem_valid;                       // Data port first
  assign own_mem  = busy_q ? own_mem_q : pick_mem;

  assign o_req = own_mem ? i_mem_req : if_req;

  // Drop valid during the done cycle so the bridge does not
  // start the same request a second time
  assign o_req_valid = busy_q ? ~i_req_done : (i_mem_valid | i_if_valid);

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      busy_q    <= 1'b0;
      own_mem_q <= 1'b0;
    end else if (!busy_q) begin
      if (i_mem_valid | i_if_valid) begin
        busy_q    <= 1'b1;
        own_mem_q <= pick_mem;
      end
    end else if (i_req_done) begin
      busy_q <= 1'b0;                                  // Release after completion
    end
  end

  // ----------------------------------------
  // Completion steering
  // ----------------------------------------
  assign o_mem_ready = i_req_done & own_mem_q;
  assign o_if_ready  = i_req_done & ~own_mem_q;

  // Shared return data, qualified by each port's ready
  assign o_if_rdata  = i_req_rdata;
  assign o_mem_rdata = i_req_rdata;
  assign o_if_err    = i_req_err;
  assign o_mem_err   = i_req_err;

endmodule

// ==== verilog/mem_subsys_top.sv ====
// Memory path top level; fetch and data ports share one AXI-lite master into the SRAM
`timescale 1ns/1ps

module mem_subsys_top (
  input  logic                         i_aclk,
  input  logic                         i_arst_n,
  // Fetch port
  input  logic                         i_if_valid,
  input  logic [axil_pkg::ADDR_W-1:0]  i_if_addr,
  output logic                         o_if_ready,
  output logic [axil_pkg::DATA_W-1:0]  o_if_rdata,
  output logic                         o_if_err,
  // Data port
  input  logic                         i_mem_valid,
  input  axil_pkg::mem_req_t           i_mem_req,
  output logic                         o_mem_ready,
  output logic [axil_pkg::DATA_W-1:0]  o_mem_rdata,
  output logic                         o_mem_err
);

  import axil_pkg::*;

  // Arbiter to bridge
  logic              req_valid;
  mem_req_t          req;
  logic              req_done;
  logic [DATA_W-1:0] req_rdata;
  logic              req_err;

  // ----------------------------------------
  // AXI-lite channels
  // ----------------------------------------
  logic     aw_valid, aw_ready;
  axil_aw_t aw;
  logic     w_valid, w_ready;
  axil_w_t  w;
  logic     b_valid, b_ready;
  axil_b_t  b;
  logic     ar_valid, ar_ready;
  axil_ar_t ar;
  logic     r_valid, r_ready;
  axil_r_t  r;

  mem_req_arbiter u_arbiter (
    .i_aclk      (i_aclk),
    .i_arst_n    (i_arst_n),
    .i_if_valid  (i_if_valid),
    .i_if_addr   (i_if_addr),
    .o_if_ready  (o_if_ready),
    .o_if_rdata  (o_if_rdata),
    .o_if_err    (o_if_err),
    .i_mem_valid (i_mem_valid),
    .i_mem_req   (i_mem_req),
    .o_mem_ready (o_mem_ready),
    .o_mem_rdata (o_mem_rdata),
    .o_mem_err   (o_mem_err),
    .o_req_valid (req_valid),
    .o_req       (req),
    .i_req_done  (req_done),
    .i_req_rdata (req_rdata),
    .i_req_err   (req_err)
  );

  axil_master_bridge u_bridge (
    .i_aclk      (i_aclk),
    .i_arst_n    (i_arst_n),
    .i_req_valid (req_valid),
    .i_req       (req),
    .o_req_done  (req_done),
    .o_req_rdata (req_rdata),
    .o_req_err   (req_err),
    .o_aw_valid  (aw_valid),
    .o_aw        (aw),
    .i_aw_ready  (aw_ready),
    .o_w_valid   (w_valid),
    .o_w         (w),
    .i_w_ready   (w_ready),
    .i_b_valid   (b_valid),
    .i_b         (b),
    .o_b_ready   (b_ready),
    .o_ar_valid  (ar_valid),
    .o_ar        (ar),
    .i_ar_ready  (ar_ready),
    .i_r_valid   (r_valid),
    .i_r         (r),
    .o_r_ready   (r_ready)
  );

  axil_sram_slave u_sram (
    .i_aclk      (i_aclk),
    .i_arst_n    (i_arst_n),
    .i_aw_valid  (aw_valid),
    .i_aw        (aw),
    .o_aw_ready  (aw_ready),
    .i_w_valid   (w_valid),
    .i_w         (w),
    .o_w_ready   (w_ready),
    .o_b_valid   (b_valid),
    .o_b         (b),
    .i_b_ready   (b_ready),
    .i_ar_valid  (ar_valid),
    .i_ar        (ar),
    .o_ar_ready  (ar_ready),
    .o_r_valid   (r_valid),
    .o_r         (r),
    .i_r_ready   (r_ready)
  );

endmodule
